//--- verilog/exu_config.svh
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// data width, also used for pc and jump targets
`define EXU_XLEN 32

// register index width
`define EXU_REG_ADDR_W 5

// one shift-add step per multiplier bit
`define EXU_MUL_STEPS `EXU_XLEN

`endif

//--- verilog/exu_op_pkg.sv
package exu_op_pkg;

    // decoded operation, one code per supported instruction
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL,
        OP_MUL,     // low word
        OP_MULHU    // high word, unsigned
    } exu_op_e;

    // which execution unit owns an op
    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } exu_unit_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } mul_state_e;

endpackage

//--- verilog/exu_bus_pkg.sv
`include "exu_config.svh"

package exu_bus_pkg;

    // decoded instruction as handed to the execute stage
    typedef struct packed {
        exu_op_pkg::exu_op_e         op;
        logic [`EXU_XLEN-1:0]        rs1;
        logic [`EXU_XLEN-1:0]        rs2;
        logic [`EXU_XLEN-1:0]        imm;
        logic [`EXU_XLEN-1:0]        pc;
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        logic                        use_imm;   // operand two from imm, not rs2
    } exu_issue_t;

    // one retired instruction
    typedef struct packed {
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        logic                        we;
        logic [`EXU_XLEN-1:0]        data;
        logic                        jump;
        logic [`EXU_XLEN-1:0]        jump_addr;
    } exu_wb_t;

endpackage

//--- verilog/exu_issue.sv
`timescale 1ns/1ps

module exu_issue (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    issue_valid_i,
    output logic                    issue_ready_o,
    input  exu_bus_pkg::exu_issue_t issue_i,
    input  logic                    alu_pending_i,
    output logic                    alu_valid_o,
    input  logic                    alu_ready_i,
    output logic                    mul_valid_o,
    input  logic                    mul_ready_i,
    output exu_bus_pkg::exu_issue_t req_o
);
    import exu_op_pkg::*;
    import exu_bus_pkg::*;

    logic       q_valid;
    exu_issue_t q_rec;
    exu_unit_e  q_unit;
    logic       drain;

    always_comb begin
        case (q_rec.op)
            OP_MUL, OP_MULHU: q_unit = UNIT_MUL;
            default:          q_unit = UNIT_ALU;
        endcase
    end

    // mul_ready_i low means the multiplier still runs or holds its result
    assign alu_valid_o = q_valid && (q_unit == UNIT_ALU) && mul_ready_i;
    // no multiply until every older alu result has left the alu path
    assign mul_valid_o = q_valid && (q_unit == UNIT_MUL) && !alu_pending_i;

    assign drain         = (alu_valid_o && alu_ready_i) || (mul_valid_o && mul_ready_i);
    assign issue_ready_o = !q_valid || drain;
    assign req_o         = q_rec;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            q_valid <= 1'b0;
        end else if (issue_ready_o) begin
            q_valid <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i && issue_ready_o) begin
            q_rec <= issue_i;
        end
    end

endmodule

//--- verilog/exu_alu.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_alu (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  exu_bus_pkg::exu_issue_t req_i,
    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output exu_bus_pkg::exu_wb_t    res_o
);
    import exu_op_pkg::*;
    import exu_bus_pkg::*;

    localparam int XW  = `EXU_XLEN;
    localparam int SHW = $clog2(`EXU_XLEN);

    logic [XW-1:0]  op2;
    logic [SHW-1:0] shamt;
    logic           lt_s;
    logic           lt_u;
    logic           eq;
    exu_wb_t        res_d;
    exu_wb_t        res_q;
    logic           res_valid_q;

    assign op2   = req_i.use_imm ? req_i.imm : req_i.rs2;
    assign shamt = op2[SHW-1:0];
    assign lt_s  = $signed(req_i.rs1) < $signed(op2);
    assign lt_u  = req_i.rs1 < op2;
    assign eq    = req_i.rs1 == req_i.rs2;   // branches always compare rs2

    always_comb begin
        logic br_lt;

        br_lt           = $signed(req_i.rs1) < $signed(req_i.rs2);
        res_d.rd        = req_i.rd;
        res_d.we        = 1'b1;
        res_d.data      = '0;
        res_d.jump      = 1'b0;
        res_d.jump_addr = '0;
        case (req_i.op)
            OP_ADD:  res_d.data = req_i.rs1 + op2;
            OP_SUB:  res_d.data = req_i.rs1 - op2;
            OP_AND:  res_d.data = req_i.rs1 & op2;
            OP_OR:   res_d.data = req_i.rs1 | op2;
            OP_XOR:  res_d.data = req_i.rs1 ^ op2;
            OP_SLL:  res_d.data = req_i.rs1 << shamt;
            OP_SRL:  res_d.data = req_i.rs1 >> shamt;
            OP_SRA:  res_d.data = $signed(req_i.rs1) >>> shamt;
            OP_SLT:  res_d.data = XW'(lt_s);
            OP_SLTU: res_d.data = XW'(lt_u);
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE: begin
                res_d.we        = 1'b0;     // branches never write a register
                res_d.jump_addr = req_i.pc + req_i.imm;
                case (req_i.op)
                    OP_BEQ:  res_d.jump = eq;
                    OP_BNE:  res_d.jump = !eq;
                    OP_BLT:  res_d.jump = br_lt;
                    default: res_d.jump = !br_lt;
                endcase
            end
            OP_JAL: begin
                res_d.we        = req_i.rd != '0;
                res_d.data      = req_i.pc + XW'(4);   // link value
                res_d.jump      = 1'b1;
                res_d.jump_addr = req_i.pc + req_i.imm;
            end
            default: res_d.we = 1'b0;   // multiply ops are never routed here
        endcase
    end

    // output register moves when empty or drained this cycle
    assign req_ready_o = !res_valid_q || res_ready_i;
    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            res_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            res_q <= res_d;
        end
    end

endmodule

//--- verilog/exu_mul.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_mul (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  exu_bus_pkg::exu_issue_t req_i,
    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output exu_bus_pkg::exu_wb_t    res_o
);
    import exu_op_pkg::*;

    localparam int XW    = `EXU_XLEN;
    localparam int CNT_W = $clog2(`EXU_MUL_STEPS);

    mul_state_e                  state_q;
    mul_state_e                  state_d;
    logic [CNT_W-1:0]            cnt_q;
    logic                        last_step;
    logic [2*XW-1:0]             acc_q;      // running product
    logic [2*XW-1:0]             mcand_q;    // shifts left each step
    logic [XW-1:0]               mplier_q;   // shifts right each step
    logic                        hi_q;       // mulhu returns the upper word
    logic [`EXU_REG_ADDR_W-1:0]  rd_q;

    assign last_step = cnt_q == CNT_W'(`EXU_MUL_STEPS - 1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (req_valid_i) state_d = ST_RUN;
            ST_RUN:  if (last_step) state_d = ST_DONE;
            ST_DONE: if (res_ready_i) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_RUN) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_valid_i) begin
            acc_q    <= '0;
            mcand_q  <= {{XW{1'b0}}, req_i.rs1};
            mplier_q <= req_i.rs2;
            hi_q     <= req_i.op == OP_MULHU;
            rd_q     <= req_i.rd;
        end else if (state_q == ST_RUN) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign req_ready_o     = state_q == ST_IDLE;
    assign res_valid_o     = state_q == ST_DONE;
    assign res_o.rd        = rd_q;
    assign res_o.we        = 1'b1;
    assign res_o.data      = hi_q ? acc_q[2*XW-1:XW] : acc_q[XW-1:0];
    assign res_o.jump      = 1'b0;
    assign res_o.jump_addr = '0;

endmodule

//--- verilog/exu_wb_arb.sv
`timescale 1ns/1ps

module exu_wb_arb (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 alu_valid_i,
    output logic                 alu_ready_o,
    input  exu_bus_pkg::exu_wb_t alu_i,
    input  logic                 mul_valid_i,
    output logic                 mul_ready_o,
    input  exu_bus_pkg::exu_wb_t mul_i,
    output logic                 alu_pending_o,
    output logic                 wb_valid_o,
    input  logic                 wb_ready_i,
    output exu_bus_pkg::exu_wb_t wb_o
);
    import exu_op_pkg::*;
    import exu_bus_pkg::*;

    logic      wb_valid_q;
    exu_wb_t   wb_q;
    exu_unit_e src_q;   // unit that produced the held record
    logic      free;
    logic      load;

    // refill in the same cycle the held record leaves
    assign free = !wb_valid_q || wb_ready_i;
    // issue ordering keeps the two units from offering at once
    assign load = free && (alu_valid_i || mul_valid_i);

    assign alu_ready_o   = free;
    assign mul_ready_o   = free;
    assign alu_pending_o = (wb_valid_q && src_q == UNIT_ALU) || alu_valid_i;
    assign wb_valid_o    = wb_valid_q;
    assign wb_o          = wb_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
            src_q      <= UNIT_ALU;
        end else if (free) begin
            wb_valid_q <= alu_valid_i || mul_valid_i;
            if (load) begin
                src_q <= alu_valid_i ? UNIT_ALU : UNIT_MUL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_q <= alu_valid_i ? alu_i : mul_i;
        end
    end

endmodule

//--- verilog/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    issue_valid_i,
    output logic                    issue_ready_o,
    input  exu_bus_pkg::exu_issue_t issue_i,
    output logic                    wb_valid_o,
    input  logic                    wb_ready_i,
    output exu_bus_pkg::exu_wb_t    wb_o
);
    import exu_bus_pkg::*;

    exu_issue_t req;            // shared request record, valids pick the unit
    logic       alu_req_valid;
    logic       alu_req_ready;
    logic       mul_req_valid;
    logic       mul_req_ready;
    exu_wb_t    alu_res;
    logic       alu_res_valid;
    logic       alu_res_ready;
    exu_wb_t    mul_res;
    logic       mul_res_valid;
    logic       mul_res_ready;
    logic       alu_pending;

    exu_issue u_issue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_ready_o(issue_ready_o),
        .issue_i      (issue_i),
        .alu_pending_i(alu_pending),
        .alu_valid_o  (alu_req_valid),
        .alu_ready_i  (alu_req_ready),
        .mul_valid_o  (mul_req_valid),
        .mul_ready_i  (mul_req_ready),
        .req_o        (req)
    );

    exu_alu u_alu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_valid_i(alu_req_valid),
        .req_ready_o(alu_req_ready),
        .req_i      (req),
        .res_valid_o(alu_res_valid),
        .res_ready_i(alu_res_ready),
        .res_o      (alu_res)
    );

    exu_mul u_mul (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_valid_i(mul_req_valid),
        .req_ready_o(mul_req_ready),
        .req_i      (req),
        .res_valid_o(mul_res_valid),
        .res_ready_i(mul_res_ready),
        .res_o      (mul_res)
    );

    exu_wb_arb u_wb_arb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .alu_valid_i  (alu_res_valid),
        .alu_ready_o  (alu_res_ready),
        .alu_i        (alu_res),
        .mul_valid_i  (mul_res_valid),
        .mul_ready_o  (mul_res_ready),
        .mul_i        (mul_res),
        .alu_pending_o(alu_pending),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_o         (wb_o)
    );

endmodule

//--- sim/exu_clkgen.sv
`timescale 1ns/1ps

module exu_clkgen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;   // released just after the edge
    end

endmodule

//--- sim/exu_props.sv
`timescale 1ns/1ps

module exu_props (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 wb_valid_i,
    input logic                 wb_ready_i,
    input exu_bus_pkg::exu_wb_t wb_i
);
    // held record must not move under back-pressure
    a_wb_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_i && !wb_ready_i |=> $stable(wb_i))
        else $error("write-back record changed while stalled");

    a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_i && !wb_ready_i |=> wb_valid_i)
        else $error("write-back valid dropped without a transfer");

    // synchronous reset clears the output register
    a_wb_reset: assert property (@(posedge clk_i) !rst_n_i |=> !wb_valid_i)
        else $error("write-back valid high after reset");

endmodule

bind exu_top exu_props u_props (
    .clk_i     (clk),
    .rst_n_i   (rst_n_i),
    .wb_valid_i(wb_valid_o),
    .wb_ready_i(wb_ready_i),
    .wb_i      (wb_o)
);

//--- sim/exu_tb.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb;
    import exu_op_pkg::*;
    import exu_bus_pkg::*;

    localparam int XW     = `EXU_XLEN;
    localparam int SHW    = $clog2(`EXU_XLEN);
    localparam int N_RAND = 40;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    logic        issue_ready;
    exu_issue_t  issue_rec;
    logic        wb_valid;
    logic        wb_ready;
    exu_wb_t     wb_rec;

    exu_issue_t  tbl_req[$];
    exu_wb_t     tbl_exp[$];
    string       tbl_name[$];
    exu_wb_t     exp_q[$];     // expected records in issue order
    string       name_q[$];
    int          acc_q[$];     // acceptance edge or -1 for no latency check
    int          cyc = 0;
    int          cyc_limit = 100000;
    int          n_pass = 0;
    int          n_fail = 0;
    logic [31:0] rng = 32'd15660;

    exu_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    exu_top DUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .issue_valid_i(issue_valid),
        .issue_ready_o(issue_ready),
        .issue_i      (issue_rec),
        .wb_valid_o   (wb_valid),
        .wb_ready_i   (wb_ready),
        .wb_o         (wb_rec)
    );

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // expected write-back from the execute rules
    function automatic exu_wb_t predict_wb(input exu_issue_t r);
        exu_wb_t         w;
        logic [XW-1:0]   b;
        logic [2*XW-1:0] prod;

        b    = r.use_imm ? r.imm : r.rs2;
        prod = {{XW{1'b0}}, r.rs1} * {{XW{1'b0}}, r.rs2};
        w    = '0;
        w.rd = r.rd;
        w.we = 1'b1;
        case (r.op)
            OP_ADD:   w.data = r.rs1 + b;
            OP_SUB:   w.data = r.rs1 - b;
            OP_AND:   w.data = r.rs1 & b;
            OP_OR:    w.data = r.rs1 | b;
            OP_XOR:   w.data = r.rs1 ^ b;
            OP_SLL:   w.data = r.rs1 << b[SHW-1:0];
            OP_SRL:   w.data = r.rs1 >> b[SHW-1:0];
            OP_SRA:   w.data = $signed(r.rs1) >>> b[SHW-1:0];
            OP_SLT:   w.data = XW'($signed(r.rs1) < $signed(b));
            OP_SLTU:  w.data = XW'(r.rs1 < b);
            OP_MUL:   w.data = prod[XW-1:0];
            OP_MULHU: w.data = prod[2*XW-1:XW];
            OP_BEQ:   w.jump = r.rs1 == r.rs2;
            OP_BNE:   w.jump = r.rs1 != r.rs2;
            OP_BLT:   w.jump = $signed(r.rs1) < $signed(r.rs2);
            OP_BGE:   w.jump = $signed(r.rs1) >= $signed(r.rs2);
            default: begin   // jal
                w.we   = r.rd != '0;
                w.data = r.pc + XW'(4);
                w.jump = 1'b1;
            end
        endcase
        if (r.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL}) begin
            w.jump_addr = r.pc + r.imm;
        end
        if (r.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE}) begin
            w.we = 1'b0;
        end
        return w;
    endfunction

    function automatic exu_issue_t random_issue();
        exu_issue_t  r;
        logic [31:0] t;

        t         = xorshift();
        r.op      = exu_op_e'(5'(t % 17));
        r.use_imm = t[8];
        r.rd      = t[13:9];
        r.rs1     = xorshift();
        r.rs2     = t[14] ? r.rs1 : xorshift();   // equal operands for taken beq
        r.imm     = xorshift();
        t         = xorshift();
        r.pc      = {t[XW-1:2], 2'b00};
        return r;
    endfunction

    task automatic add_row(input string name, input exu_op_e op,
                           input logic [XW-1:0] a, b, imm, input int use_imm,
                           input logic [XW-1:0] pc, input int rd, we,
                           input logic [XW-1:0] data, input int jump,
                           input logic [XW-1:0] jaddr);
        exu_issue_t r;
        exu_wb_t    e;

        r = '{op: op, rs1: a, rs2: b, imm: imm, pc: pc,
              rd: `EXU_REG_ADDR_W'(rd), use_imm: use_imm != 0};
        e = '{rd: `EXU_REG_ADDR_W'(rd), we: we != 0, data: data,
              jump: jump != 0, jump_addr: jaddr};
        tbl_req.push_back(r);
        tbl_exp.push_back(e);
        tbl_name.push_back(name);
    endtask

    task automatic load_table();
        // name, op, rs1, rs2, imm, use_imm, pc, rd | we, data, jump, jump_addr
        add_row("add", OP_ADD, 'h5, 'h7, 'h0, 0, 'h100, 1, 1, 'hC, 0, 'h0);
        add_row("addi", OP_ADD, 'hFFFF_FFF0, 'h0, 'h20, 1, 'h100, 2, 1, 'h10, 0, 'h0);
        add_row("sub", OP_SUB, 'h3, 'h5, 'h0, 0, 'h100, 3, 1, 'hFFFF_FFFE, 0, 'h0);
        add_row("andi", OP_AND, 'hF0F0_1234, 'h0, 'hFF00, 1, 'h100, 4, 1, 'h1200, 0, 'h0);
        add_row("or", OP_OR, 'hA000_0000, 'h5, 'h0, 0, 'h100, 5, 1, 'hA000_0005, 0, 'h0);
        add_row("xori", OP_XOR, 'hFFFF_0000, 'h0, 'h0F0F_0F0F, 1, 'h100, 6, 1,
                'hF0F0_0F0F, 0, 'h0);
        add_row("sll", OP_SLL, 'hABC, 'd20, 'h0, 0, 'h100, 7, 1, 'hABC0_0000, 0, 'h0);
        add_row("srli", OP_SRL, 'h8000_0000, 'h0, 'd17, 1, 'h100, 8, 1, 'h4000, 0, 'h0);
        add_row("sra", OP_SRA, 'h8000_0000, 'd28, 'h0, 0, 'h100, 9, 1, 'hFFFF_FFF8, 0, 'h0);
        add_row("slt", OP_SLT, 'hFFFF_FFFF, 'h1, 'h0, 0, 'h100, 10, 1, 'h1, 0, 'h0);
        add_row("sltiu", OP_SLTU, 'h1, 'h0, 'hFFFF_FFFF, 1, 'h100, 11, 1, 'h1, 0, 'h0);
        add_row("beq_t", OP_BEQ, 'h9, 'h9, 'h40, 0, 'h100, 0, 0, 'h0, 1, 'h140);
        add_row("beq_n", OP_BEQ, 'h10, 'h8, 'h10, 1, 'h100, 0, 0, 'h0, 0, 'h110);
        add_row("bne_n", OP_BNE, 'h9, 'h9, 'h20, 0, 'h200, 0, 0, 'h0, 0, 'h220);
        add_row("bne_t", OP_BNE, 'h9, 'h8, 'h20, 0, 'h200, 0, 0, 'h0, 1, 'h220);
        add_row("blt_t", OP_BLT, 'hFFFF_FFFE, 'h3, 'hFFFF_FFF0, 0, 'h300, 0, 0, 'h0, 1, 'h2F0);
        add_row("blt_n", OP_BLT, 'h3, 'hFFFF_FFFE, 'h10, 0, 'h300, 0, 0, 'h0, 0, 'h310);
        add_row("bge_n", OP_BGE, 'hFFFF_FFFE, 'h3, 'h8, 0, 'h300, 0, 0, 'h0, 0, 'h308);
        add_row("bge_t", OP_BGE, 'h3, 'hFFFF_FFFE, 'h8, 0, 'h300, 0, 0, 'h0, 1, 'h308);
        add_row("jal", OP_JAL, 'h0, 'h0, 'h100, 0, 'h400, 1, 1, 'h404, 1, 'h500);
        add_row("jal_x0", OP_JAL, 'h0, 'h0, 'hFFFF_FFFC, 0, 'h404, 0, 0, 'h408, 1, 'h400);
        add_row("mul", OP_MUL, 'hFFFF_FFFF, 'hFFFF_FFFF, 'h0, 0, 'h0, 13, 1, 'h1, 0, 'h0);
        add_row("mulhu", OP_MULHU, 'hFFFF_FFFF, 'hFFFF_FFFF, 'h0, 0, 'h0, 14, 1,
                'hFFFF_FFFE, 0, 'h0);
        add_row("mul_dec", OP_MUL, 'd1234, 'd5678, 'h0, 0, 'h0, 15, 1, 'd7006652, 0, 'h0);
        add_row("mulhu_3", OP_MULHU, 'h1_0000, 'h3_0000, 'h0, 0, 'h0, 16, 1, 'h3, 0, 'h0);
    endtask

    task automatic expect_record(input exu_wb_t e, input string name, input int acc);
        exp_q.push_back(e);
        name_q.push_back(name);
        acc_q.push_back(acc);
    endtask

    task automatic issue_one(input exu_issue_t r, input exu_wb_t e, input string name,
                             input bit check_lat);
        @(posedge clk);
        #1;
        issue_valid = 1'b1;
        issue_rec   = r;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        expect_record(e, name, check_lat ? cyc + 1 : -1);   // taken at the next edge
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
            $display("timeout after %0d cycles with %0d records still outstanding",
                     cyc, exp_q.size());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // write-back transfers are seen at the falling edge before they happen
    always @(negedge clk) begin
        exu_wb_t e;
        string   nm;
        int      acc;

        if (rst_n && wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("write-back record %h arrived with nothing outstanding", wb_rec);
                n_fail++;
            end else begin
                e   = exp_q.pop_front();
                nm  = name_q.pop_front();
                acc = acc_q.pop_front();
                if (wb_rec !== e) begin
                    $display("ERR %s expected %h actual %h", nm, e, wb_rec);
                    n_fail++;
                end else if (acc >= 0 && cyc + 1 - acc != 3) begin
                    $display("ERR %s latency expected 3 actual %0d", nm, cyc + 1 - acc);
                    n_fail++;
                end else begin
                    $display("ok   %s", nm);
                    n_pass++;
                end
            end
        end
    end

    initial begin
        exu_issue_t  r;
        logic [31:0] rnd;
        int          i;
        int          sent;
        bit          taken;

        issue_valid = 1'b0;
        issue_rec   = '0;
        wb_ready    = 1'b1;
        load_table();
        cyc_limit = (tbl_req.size() + N_RAND) * (`EXU_MUL_STEPS + 4) * 2 + 16;
        wait (rst_n === 1'b1);
        @(negedge clk);
        if (wb_valid !== 1'b0 || issue_ready !== 1'b1) begin
            $display("ERR reset expected valid=0 ready=1 actual valid=%b ready=%b",
                     wb_valid, issue_ready);
            n_fail++;
        end else begin
            $display("ok   reset");
            n_pass++;
        end

        // directed rows one at a time on an empty pipeline
        for (i = 0; i < tbl_req.size(); i++) begin
            issue_one(tbl_req[i], tbl_exp[i], tbl_name[i],
                      !(tbl_req[i].op inside {OP_MUL, OP_MULHU}));
            while (exp_q.size() != 0) @(posedge clk);
        end

        sent  = 0;
        taken = 1'b0;
        while (sent < N_RAND || exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            rnd      = xorshift();
            wb_ready = rnd[7];   // random back-pressure
            if (taken) begin
                issue_valid = 1'b0;
            end
            if (!issue_valid && sent < N_RAND) begin
                r           = random_issue();
                issue_valid = 1'b1;
                issue_rec   = r;
            end
            @(negedge clk);
            taken = issue_valid && issue_ready;
            if (taken) begin
                expect_record(predict_wb(issue_rec),
                              $sformatf("rand%0d_%s", sent, issue_rec.op.name()), -1);
                sent++;
            end
        end

        @(posedge clk);
        #1;
        wb_ready = 1'b1;
        repeat (5) @(posedge clk);   // room for a duplicate to show up
        $display("tests: %0d passed, %0d failed, %0d expected",
                 n_pass, n_fail, tbl_req.size() + N_RAND + 1);
        if (n_fail == 0 && n_pass == tbl_req.size() + N_RAND + 1) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/exu_op_pkg.sv
verilog/exu_bus_pkg.sv
verilog/exu_issue.sv
verilog/exu_alu.sv
verilog/exu_mul.sv
verilog/exu_wb_arb.sv
verilog/exu_top.sv
sim/exu_clkgen.sv
sim/exu_props.sv
sim/exu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = exu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "FAIL: no result in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
